// ==== src/pe_pkg.sv ====
package pe_pkg;

    //////////////////////////////
    // Widths and geometry
    //////////////////////////////

    localparam int ADDR_W       = 32;
    localparam int DATA_W       = 32;
    localparam int MEM_ADDR_W   = 24;
    localparam int N_PE_X       = 2;
    localparam int N_PE_Y       = 2;
    localparam int BR_ID_W      = 5;
    localparam int BR_KSVC_W    = 5;
    localparam int BR_MON_SVC_W = 2;

    // Region is selected by the top address byte
    typedef enum logic [7:0] {
        REG_IMEM = 8'h00,
        REG_DMEM = 8'h01,
        REG_RTC  = 8'h02,
        REG_PLIC = 8'h04
    } region_e;

    // RTC register offsets
    localparam logic [3:0] RTC_MTIME_LO = 4'h0;
    localparam logic [3:0] RTC_MTIME_HI = 4'h4;
    localparam logic [3:0] RTC_CMP_LO   = 4'h8;
    localparam logic [3:0] RTC_CMP_HI   = 4'hC;

    // PLIC register offsets
    localparam logic [3:0] PLIC_ENABLE  = 4'h0;
    localparam logic [3:0] PLIC_PENDING = 4'h4;
    localparam logic [3:0] PLIC_CLAIM   = 4'h8;

    typedef enum logic [1:0] {
        BR_SVC_ALL,
        BR_SVC_TGT,
        BR_SVC_MON
    } br_svc_e;

    //////////////////////////////
    // Bus structs
    //////////////////////////////

    typedef struct packed {
        logic                  en;
        logic [3:0]            we;
        logic [ADDR_W-1:0]     addr;
        logic [DATA_W-1:0]     wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                  en;
        logic                  we;
        logic [3:0]            offset;
        logic [DATA_W-1:0]     wdata;
    } periph_req_t;

    typedef struct packed {
        logic [3:0]            we;
        logic [ADDR_W-1:0]     addr;
        logic [DATA_W-1:0]     wdata;
    } dma_req_t;

    typedef struct packed {
        logic [3:0]            we;
        logic [MEM_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     wdata;
    } mem_req_t;

    //////////////////////////////
    // Broadcast structs
    //////////////////////////////

    typedef struct packed {
        br_svc_e               service;
        logic [BR_KSVC_W-1:0]  ksvc;
        logic [15:0]           producer;
        logic [15:0]           seq_source;
        logic [15:0]           seq_target;
        logic [BR_ID_W-1:0]    id;
        logic [31:0]           payload;
    } br_flit_t;

    // NI side, source and id are stamped on the way out
    typedef struct packed {
        br_svc_e               service;
        logic [BR_KSVC_W-1:0]  ksvc;
        logic [15:0]           producer;
        logic [15:0]           seq_target;
        logic [31:0]           payload;
    } br_out_t;

    typedef struct packed {
        logic [31:0]           payload;
        logic [15:0]           seq_source;
        logic [15:0]           producer;
        logic [BR_MON_SVC_W-1:0] msvc;
    } br_mon_t;

    typedef struct packed {
        logic [31:0]           payload;
        logic [15:0]           seq_source;
        logic [15:0]           producer;
        logic [BR_KSVC_W-1:0]  ksvc;
    } br_svc_t;

endpackage

// ==== src/pe_bus_ctrl.sv ====
module pe_bus_ctrl
    import pe_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,

    // CPU data bus
    input  cpu_req_t          cpu_req_i,
    output logic [DATA_W-1:0] cpu_rdata_o,

    // Peripherals and data memory
    output periph_req_t       rtc_req_o,
    input  logic [DATA_W-1:0] rtc_rdata_i,
    output periph_req_t       plic_req_o,
    input  logic [DATA_W-1:0] plic_rdata_i,
    output logic              dmem_en_o,
    output mem_req_t          dmem_req_o,
    input  logic [DATA_W-1:0] dmem_rdata_i,

    // DMA port
    input  dma_req_t          dma_req_i,
    output logic              idma_en_o,
    output logic              ddma_en_o,
    output mem_req_t          dma_mem_o,
    input  logic [DATA_W-1:0] idma_rdata_i,
    input  logic [DATA_W-1:0] ddma_rdata_i,
    output logic [DATA_W-1:0] dma_rdata_o
);

    //////////////////////////////
    // CPU decode
    //////////////////////////////

    region_e cpu_region;
    logic    cpu_wr;
    logic    rtc_en;
    logic    plic_en;
    logic    rtc_en_q;
    logic    plic_en_q;

    assign cpu_region = region_e'(cpu_req_i.addr[ADDR_W-1 -: 8]);
    assign cpu_wr     = |cpu_req_i.we;

    assign dmem_en_o = cpu_req_i.en && (cpu_region == REG_DMEM);
    assign rtc_en    = cpu_req_i.en && (cpu_region == REG_RTC);
    assign plic_en   = cpu_req_i.en && (cpu_region == REG_PLIC);

    assign dmem_req_o = '{we: cpu_req_i.we, addr: cpu_req_i.addr[MEM_ADDR_W-1:0],
                          wdata: cpu_req_i.wdata};
    assign rtc_req_o  = '{en: rtc_en, we: cpu_wr, offset: cpu_req_i.addr[3:0],
                          wdata: cpu_req_i.wdata};
    assign plic_req_o = '{en: plic_en, we: cpu_wr, offset: cpu_req_i.addr[3:0],
                          wdata: cpu_req_i.wdata};

    // Read data returns one cycle after the request
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rtc_en_q  <= 1'b0;
            plic_en_q <= 1'b0;
        end else begin
            rtc_en_q  <= rtc_en;
            plic_en_q <= plic_en;
        end
    end

    always_comb begin
        if (rtc_en_q)
            cpu_rdata_o = rtc_rdata_i;
        else if (plic_en_q)
            cpu_rdata_o = plic_rdata_i;
        else
            cpu_rdata_o = dmem_rdata_i;
    end

    //////////////////////////////
    // DMA bank select
    //////////////////////////////

    region_e dma_region;

    assign dma_region = region_e'(dma_req_i.addr[ADDR_W-1 -: 8]);
    assign idma_en_o  = (dma_region == REG_IMEM);
    assign ddma_en_o  = (dma_region == REG_DMEM);

    assign dma_mem_o = '{we: dma_req_i.we, addr: dma_req_i.addr[MEM_ADDR_W-1:0],
                         wdata: dma_req_i.wdata};

    // Bit 24 picks the bank, anything higher reads as zero
    always_comb begin
        if (dma_req_i.addr[ADDR_W-1:25] == '0)
            dma_rdata_o = dma_req_i.addr[24] ? ddma_rdata_i : idma_rdata_i;
        else
            dma_rdata_o = '0;
    end

endmodule

// ==== src/pe_rtc.sv ====
module pe_rtc
    import pe_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,

    input  periph_req_t       req_i,
    output logic [DATA_W-1:0] rdata_o,

    output logic              mti_o
);

    logic [63:0]       mtime_q;
    logic [63:0]       cmp_q;
    logic [DATA_W-1:0] rdata_q;
    logic              wr_en;

    assign wr_en = req_i.en && req_i.we;

    //////////////////////////////
    // Counter and compare
    //////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni)
            mtime_q <= '0;
        else
            mtime_q <= mtime_q + 64'd1;
    end

    // Compare starts at the top so no interrupt fires after reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cmp_q <= '1;
        end else if (wr_en) begin
            case (req_i.offset)
                RTC_CMP_LO: cmp_q[31:0]  <= req_i.wdata;
                RTC_CMP_HI: cmp_q[63:32] <= req_i.wdata;
                default: ;
            endcase
        end
    end

    assign mti_o = (mtime_q >= cmp_q);

    //////////////////////////////
    // Read port
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (req_i.en) begin
            case (req_i.offset)
                RTC_MTIME_LO: rdata_q <= mtime_q[31:0];
                RTC_MTIME_HI: rdata_q <= mtime_q[63:32];
                RTC_CMP_LO:   rdata_q <= cmp_q[31:0];
                RTC_CMP_HI:   rdata_q <= cmp_q[63:32];
                default:      rdata_q <= '0;
            endcase
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== src/pe_plic.sv ====
module pe_plic
    import pe_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,

    input  periph_req_t       req_i,
    output logic [DATA_W-1:0] rdata_o,

    input  logic              irq_src_i,
    input  logic              irq_ack_i,
    output logic              mei_o
);

    logic              enable_q;
    logic              pending_q;
    logic              claim;
    logic [DATA_W-1:0] rdata_q;

    assign mei_o = pending_q && enable_q;
    assign claim = req_i.en && !req_i.we && (req_i.offset == PLIC_CLAIM);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q  <= 1'b0;
            pending_q <= 1'b0;
        end else begin
            if (req_i.en && req_i.we && (req_i.offset == PLIC_ENABLE))
                enable_q <= req_i.wdata[0];
            // Clear wins, a held source sets pending again next cycle
            if ((claim && mei_o) || irq_ack_i)
                pending_q <= 1'b0;
            else if (irq_src_i)
                pending_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.en) begin
            case (req_i.offset)
                PLIC_ENABLE:  rdata_q <= {{(DATA_W-1){1'b0}}, enable_q};
                PLIC_PENDING: rdata_q <= {{(DATA_W-1){1'b0}}, pending_q};
                PLIC_CLAIM:   rdata_q <= {{(DATA_W-1){1'b0}}, mei_o};
                default:      rdata_q <= '0;
            endcase
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== src/br_local_port.sv ====
module br_local_port
    import pe_pkg::*;
#(
    parameter logic [15:0] SEQ_ADDR = 16'h0000
) (
    input  logic     clk_i,
    input  logic     rst_ni,

    // Inbound from the broadcast router
    input  logic     br_req_i,
    input  br_flit_t br_flit_i,
    output logic     br_ack_o,

    // Split streams towards the NI
    output logic     mon_req_o,
    output br_mon_t  mon_flit_o,
    input  logic     mon_ack_i,
    output logic     svc_req_o,
    output br_svc_t  svc_flit_o,
    input  logic     svc_ack_i,

    // Outbound from the NI
    input  logic     ni_req_i,
    input  br_out_t  ni_flit_i,
    output logic     ni_ack_o,

    // Outbound to the broadcast router
    output logic     br_req_o,
    output br_flit_t br_flit_o,
    input  logic     br_ack_i
);

    //////////////////////////////
    // Inbound split
    //////////////////////////////

    logic is_mon;

    assign is_mon    = (br_flit_i.service == BR_SVC_MON);
    assign mon_req_o = br_req_i && is_mon;
    assign svc_req_o = br_req_i && !is_mon;
    assign br_ack_o  = is_mon ? mon_ack_i : svc_ack_i;

    // Monitor code lives in the low bits of ksvc
    assign mon_flit_o = '{payload: br_flit_i.payload, seq_source: br_flit_i.seq_source,
                          producer: br_flit_i.producer,
                          msvc: br_flit_i.ksvc[BR_MON_SVC_W-1:0]};
    assign svc_flit_o = '{payload: br_flit_i.payload, seq_source: br_flit_i.seq_source,
                          producer: br_flit_i.producer, ksvc: br_flit_i.ksvc};

    //////////////////////////////
    // Outbound stamping
    //////////////////////////////

    logic [BR_ID_W-1:0] id_q;

    // Wraps naturally at 2**BR_ID_W
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni)
            id_q <= '0;
        else if (br_ack_i)
            id_q <= id_q + 1'b1;
    end

    assign br_req_o = ni_req_i;
    assign ni_ack_o = br_ack_i;

    assign br_flit_o = '{service: ni_flit_i.service, ksvc: ni_flit_i.ksvc,
                         producer: ni_flit_i.producer, seq_source: SEQ_ADDR,
                         seq_target: ni_flit_i.seq_target, id: id_q,
                         payload: ni_flit_i.payload};

endmodule

// ==== src/pe_periph_top.sv ====
module pe_periph_top
    import pe_pkg::*;
#(
    parameter int PE_X = 0,
    parameter int PE_Y = 0
) (
    input  logic              clk_i,
    input  logic              rst_ni,

    // CPU data bus and data memory
    input  cpu_req_t          cpu_req_i,
    output logic [DATA_W-1:0] cpu_rdata_o,
    output logic              dmem_en_o,
    output mem_req_t          dmem_req_o,
    input  logic [DATA_W-1:0] dmem_rdata_i,

    // DMA towards the memory banks
    input  dma_req_t          dma_req_i,
    output logic              idma_en_o,
    output logic              ddma_en_o,
    output mem_req_t          dma_mem_o,
    input  logic [DATA_W-1:0] idma_rdata_i,
    input  logic [DATA_W-1:0] ddma_rdata_i,
    output logic [DATA_W-1:0] dma_rdata_o,

    // Interrupts
    input  logic              irq_src_i,
    input  logic              irq_ack_i,
    output logic              mei_o,
    output logic              mti_o,

    // Broadcast router local port
    input  logic              br_req_i,
    input  br_flit_t          br_flit_i,
    output logic              br_ack_o,
    output logic              br_req_o,
    output br_flit_t          br_flit_o,
    input  logic              br_ack_i,

    // NI side of the broadcast port
    output logic              mon_req_o,
    output br_mon_t           mon_flit_o,
    input  logic              mon_ack_i,
    output logic              svc_req_o,
    output br_svc_t           svc_flit_o,
    input  logic              svc_ack_i,
    input  logic              ni_req_i,
    input  br_out_t           ni_flit_i,
    output logic              ni_ack_o
);

    // Row major index, coordinates folded into the mesh
    localparam logic [15:0] SEQ_ADDR = 16'((PE_Y % N_PE_Y) * N_PE_X + (PE_X % N_PE_X));

    periph_req_t       rtc_req;
    periph_req_t       plic_req;
    logic [DATA_W-1:0] rtc_rdata;
    logic [DATA_W-1:0] plic_rdata;

    pe_bus_ctrl u_bus_ctrl (
        .clk_i, .rst_ni, .cpu_req_i, .cpu_rdata_o,
        .rtc_req_o (rtc_req), .rtc_rdata_i (rtc_rdata),
        .plic_req_o (plic_req), .plic_rdata_i (plic_rdata),
        .dmem_en_o, .dmem_req_o, .dmem_rdata_i,
        .dma_req_i, .idma_en_o, .ddma_en_o, .dma_mem_o,
        .idma_rdata_i, .ddma_rdata_i, .dma_rdata_o
    );

    pe_rtc u_rtc (
        .clk_i, .rst_ni, .req_i (rtc_req), .rdata_o (rtc_rdata), .mti_o
    );

    pe_plic u_plic (
        .clk_i, .rst_ni, .req_i (plic_req), .rdata_o (plic_rdata),
        .irq_src_i, .irq_ack_i, .mei_o
    );

    br_local_port #(
        .SEQ_ADDR (SEQ_ADDR)
    ) u_br_local_port (
        .clk_i, .rst_ni, .br_req_i, .br_flit_i, .br_ack_o,
        .mon_req_o, .mon_flit_o, .mon_ack_i, .svc_req_o, .svc_flit_o, .svc_ack_i,
        .ni_req_i, .ni_flit_i, .ni_ack_o, .br_req_o, .br_flit_o, .br_ack_i
    );

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock (
    output logic clk_o,
    output logic rst_no
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial clk_o = 1'b0;
    always #10 clk_o = ~clk_o;

    initial begin
        rst_no = 1'b0;
        repeat (8) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

// ==== verification/tb_pe_periph.sv ====
module tb_pe_periph
    import pe_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Roughly ten times the length of all tests
    localparam int TIMEOUT_CYCLES = 2000;

    logic              clk;
    logic              rst_n;
    cpu_req_t          cpu_req;
    logic [DATA_W-1:0] cpu_rdata;
    logic              dmem_en;
    mem_req_t          dmem_req;
    logic [DATA_W-1:0] dmem_rdata;
    dma_req_t          dma_req;
    logic              idma_en;
    logic              ddma_en;
    mem_req_t          dma_mem;
    logic [DATA_W-1:0] idma_rdata;
    logic [DATA_W-1:0] ddma_rdata;
    logic [DATA_W-1:0] dma_rdata;
    logic              irq_src;
    logic              irq_ack;
    logic              mei;
    logic              mti;
    logic              br_req_in;
    br_flit_t          br_flit_in;
    logic              br_ack_out;
    logic              br_req_out;
    br_flit_t          br_flit_out;
    logic              br_ack_in;
    logic              mon_req;
    br_mon_t           mon_flit;
    logic              mon_ack;
    logic              svc_req;
    br_svc_t           svc_flit;
    logic              svc_ack;
    logic              ni_req;
    br_out_t           ni_flit;
    logic              ni_ack;

    int          errors;
    int          test_errors;
    int          checks;
    int          cycles;
    logic [31:0] rng_state;

    tb_clock u_clock (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    pe_periph_top #(
        .PE_X (1),
        .PE_Y (1)
    ) dut (
        .clk_i (clk), .rst_ni (rst_n),
        .cpu_req_i (cpu_req), .cpu_rdata_o (cpu_rdata),
        .dmem_en_o (dmem_en), .dmem_req_o (dmem_req), .dmem_rdata_i (dmem_rdata),
        .dma_req_i (dma_req), .idma_en_o (idma_en), .ddma_en_o (ddma_en),
        .dma_mem_o (dma_mem), .idma_rdata_i (idma_rdata), .ddma_rdata_i (ddma_rdata),
        .dma_rdata_o (dma_rdata),
        .irq_src_i (irq_src), .irq_ack_i (irq_ack), .mei_o (mei), .mti_o (mti),
        .br_req_i (br_req_in), .br_flit_i (br_flit_in), .br_ack_o (br_ack_out),
        .br_req_o (br_req_out), .br_flit_o (br_flit_out), .br_ack_i (br_ack_in),
        .mon_req_o (mon_req), .mon_flit_o (mon_flit), .mon_ack_i (mon_ack),
        .svc_req_o (svc_req), .svc_flit_o (svc_flit), .svc_ack_i (svc_ack),
        .ni_req_i (ni_req), .ni_flit_i (ni_flit), .ni_ack_o (ni_ack)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [ADDR_W-1:0] reg_addr(input region_e region, input logic [3:0] off);
        return {region, 20'h0, off};
    endfunction

    task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_mem(input string name, input mem_req_t got, input mem_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mon(input br_mon_t got, input br_mon_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("mismatch at %0t: mon_flit_o is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_svc(input br_svc_t got, input br_svc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("mismatch at %0t: svc_flit_o is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_flit(input br_flit_t got, input br_flit_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("mismatch at %0t: br_flit_o is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0)
            $display("test %s passed", name);
        else
            $display("test %s failed with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    // Data is sampled mid cycle after the request
    task automatic cpu_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        @(posedge clk);
        cpu_req <= '{en: 1'b1, we: 4'h0, addr: addr, wdata: '0};
        @(posedge clk);
        cpu_req <= '0;
        @(negedge clk);
        data = cpu_rdata;
    endtask

    task automatic cpu_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge clk);
        cpu_req <= '{en: 1'b1, we: 4'hF, addr: addr, wdata: data};
        @(posedge clk);
        cpu_req <= '0;
        @(negedge clk);
    endtask

    task automatic make_flit(input br_svc_e svc, output br_flit_t f);
        logic [31:0] a;
        logic [31:0] b;
        a = xorshift32();
        b = xorshift32();
        f.service    = svc;
        f.ksvc       = a[4:0];
        f.producer   = a[31:16];
        f.seq_source = b[15:0];
        f.seq_target = b[31:16];
        f.id         = a[9:5];
        f.payload    = xorshift32();
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_memory_map();
        logic [31:0] r;
        mem_req_t    mem_exp;
        r = xorshift32();
        @(posedge clk);
        cpu_req    <= '{en: 1'b1, we: 4'hF, addr: {8'h01, r[23:0]}, wdata: r};
        dma_req    <= '{we: 4'h3, addr: {8'h00, r[23:0]}, wdata: ~r};
        dmem_rdata <= r ^ 32'h3c3c_3c3c;
        idma_rdata <= ~r;
        ddma_rdata <= r ^ 32'h5a5a_5a5a;
        @(negedge clk);
        check_bit("dmem_en_o", dmem_en, 1'b1);
        mem_exp = '{we: 4'hF, addr: r[23:0], wdata: r};
        check_mem("dmem_req_o", dmem_req, mem_exp);
        mem_exp = '{we: 4'h3, addr: r[23:0], wdata: ~r};
        check_mem("dma_mem_o", dma_mem, mem_exp);
        check_bit("idma_en_o", idma_en, 1'b1);
        check_bit("ddma_en_o", ddma_en, 1'b0);
        check_word("dma_rdata_o", dma_rdata, ~r);
        @(posedge clk);
        cpu_req <= '{en: 1'b1, we: 4'h0, addr: reg_addr(REG_RTC, RTC_MTIME_LO), wdata: '0};
        dma_req <= '{we: 4'h0, addr: {8'h01, r[23:0]}, wdata: '0};
        @(negedge clk);
        // Previous access went to data memory
        check_word("cpu_rdata_o", cpu_rdata, r ^ 32'h3c3c_3c3c);
        check_bit("dmem_en_o", dmem_en, 1'b0);
        check_bit("idma_en_o", idma_en, 1'b0);
        check_bit("ddma_en_o", ddma_en, 1'b1);
        check_word("dma_rdata_o", dma_rdata, r ^ 32'h5a5a_5a5a);
        @(posedge clk);
        cpu_req <= '{en: 1'b1, we: 4'h0, addr: reg_addr(REG_PLIC, PLIC_PENDING), wdata: '0};
        dma_req <= '{we: 4'h0, addr: {8'h02, r[23:0]}, wdata: '0};
        @(negedge clk);
        check_bit("dmem_en_o", dmem_en, 1'b0);
        check_bit("idma_en_o", idma_en, 1'b0);
        check_bit("ddma_en_o", ddma_en, 1'b0);
        check_word("dma_rdata_o", dma_rdata, 32'h0);
        @(posedge clk);
        cpu_req <= '0;
        dma_req <= '0;
        finish_test("memory_map");
    endtask

    task automatic test_rtc_count();
        logic [31:0] d;
        logic [31:0] t0;
        logic [31:0] t1;
        int          k;
        k = 3 + int'(xorshift32() % 8);
        // Compare register still at its reset value
        cpu_read(reg_addr(REG_RTC, RTC_CMP_LO), d);
        check_word("rtc cmp_lo", d, 32'hFFFF_FFFF);
        cpu_read(reg_addr(REG_RTC, RTC_MTIME_LO), t0);
        repeat (k - 2) @(posedge clk);
        cpu_read(reg_addr(REG_RTC, RTC_MTIME_LO), t1);
        check_word("mtime delta", t1 - t0, 32'(k));
        finish_test("rtc_count");
    endtask

    task automatic test_timer_irq();
        logic [31:0] v;
        int          n;
        cpu_read(reg_addr(REG_RTC, RTC_MTIME_LO), v);
        cpu_write(reg_addr(REG_RTC, RTC_CMP_LO), v + 32'd12);
        cpu_write(reg_addr(REG_RTC, RTC_CMP_HI), 32'd0);
        // Here mtime is v + 5 and seven counts short
        check_bit("mti_o", mti, 1'b0);
        n = 0;
        while (!mti && n < 32) begin
            @(posedge clk);
            @(negedge clk);
            n++;
        end
        check_word("cycles until mti_o", 32'(n), 32'd7);
        @(posedge clk);
        @(negedge clk);
        check_bit("mti_o", mti, 1'b1);
        cpu_write(reg_addr(REG_RTC, RTC_CMP_HI), 32'hFFFF_FFFF);
        check_bit("mti_o", mti, 1'b0);
        finish_test("timer_irq");
    endtask

    task automatic test_plic();
        logic [31:0] d;
        @(posedge clk);
        irq_src <= 1'b1;
        @(posedge clk);
        irq_src <= 1'b0;
        @(negedge clk);
        check_bit("mei_o", mei, 1'b0);
        cpu_read(reg_addr(REG_PLIC, PLIC_PENDING), d);
        check_word("plic pending", d, 32'd1);
        cpu_write(reg_addr(REG_PLIC, PLIC_ENABLE), 32'd1);
        check_bit("mei_o", mei, 1'b1);
        cpu_read(reg_addr(REG_PLIC, PLIC_CLAIM), d);
        check_word("plic claim", d, 32'd1);
        check_bit("mei_o", mei, 1'b0);
        cpu_read(reg_addr(REG_PLIC, PLIC_CLAIM), d);
        check_word("plic second claim", d, 32'd0);
        // Acknowledge clears a fresh request
        @(posedge clk);
        irq_src <= 1'b1;
        @(posedge clk);
        irq_src <= 1'b0;
        @(negedge clk);
        check_bit("mei_o", mei, 1'b1);
        @(posedge clk);
        irq_ack <= 1'b1;
        @(posedge clk);
        irq_ack <= 1'b0;
        @(negedge clk);
        check_bit("mei_o", mei, 1'b0);
        cpu_read(reg_addr(REG_PLIC, PLIC_PENDING), d);
        check_word("plic pending", d, 32'd0);
        finish_test("plic");
    endtask

    task automatic test_br_split();
        br_flit_t f;
        br_mon_t  mon_exp;
        br_svc_t  svc_exp;
        make_flit(BR_SVC_MON, f);
        mon_exp = '{payload: f.payload, seq_source: f.seq_source, producer: f.producer,
                    msvc: f.ksvc[BR_MON_SVC_W-1:0]};
        @(posedge clk);
        br_req_in  <= 1'b1;
        br_flit_in <= f;
        svc_ack    <= 1'b1;
        @(negedge clk);
        check_bit("mon_req_o", mon_req, 1'b1);
        check_bit("svc_req_o", svc_req, 1'b0);
        check_mon(mon_flit, mon_exp);
        check_bit("br_ack_o", br_ack_out, 1'b0);
        @(posedge clk);
        mon_ack <= 1'b1;
        svc_ack <= 1'b0;
        @(negedge clk);
        check_bit("br_ack_o", br_ack_out, 1'b1);
        make_flit(BR_SVC_TGT, f);
        svc_exp = '{payload: f.payload, seq_source: f.seq_source, producer: f.producer,
                    ksvc: f.ksvc};
        @(posedge clk);
        br_flit_in <= f;
        @(negedge clk);
        check_bit("mon_req_o", mon_req, 1'b0);
        check_bit("svc_req_o", svc_req, 1'b1);
        check_svc(svc_flit, svc_exp);
        check_bit("br_ack_o", br_ack_out, 1'b0);
        @(posedge clk);
        mon_ack <= 1'b0;
        svc_ack <= 1'b1;
        @(negedge clk);
        check_bit("br_ack_o", br_ack_out, 1'b1);
        @(posedge clk);
        br_req_in <= 1'b0;
        svc_ack   <= 1'b0;
        @(negedge clk);
        check_bit("svc_req_o", svc_req, 1'b0);
        finish_test("br_split");
    endtask

    task automatic test_br_stamp();
        br_out_t     o;
        br_flit_t    exp;
        logic [31:0] a;
        logic [31:0] b;
        int          i;
        for (i = 0; i < 34; i++) begin
            a = xorshift32();
            b = xorshift32();
            o = '{service: (i % 2 == 1) ? BR_SVC_TGT : BR_SVC_ALL, ksvc: a[4:0],
                  producer: a[31:16], seq_target: b[15:0], payload: a ^ b};
            exp = '{service: o.service, ksvc: o.ksvc, producer: o.producer,
                    seq_source: 16'd3, seq_target: o.seq_target,
                    id: BR_ID_W'(i % 32), payload: o.payload};
            @(posedge clk);
            ni_req  <= 1'b1;
            ni_flit <= o;
            @(negedge clk);
            check_bit("br_req_o", br_req_out, 1'b1);
            check_bit("ni_ack_o", ni_ack, 1'b0);
            check_flit(br_flit_out, exp);
            @(posedge clk);
            br_ack_in <= 1'b1;
            @(negedge clk);
            check_bit("ni_ack_o", ni_ack, 1'b1);
            @(posedge clk);
            br_ack_in <= 1'b0;
            ni_req    <= 1'b0;
        end
        @(negedge clk);
        check_bit("br_req_o", br_req_out, 1'b0);
        finish_test("br_stamp");
    endtask

    //////////////////////////////
    // Run control
    //////////////////////////////

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        errors      = 0;
        test_errors = 0;
        checks      = 0;
        cycles      = 0;
        rng_state   = 32'he5ca;
        cpu_req     = '0;
        dmem_rdata  = 32'h0;
        dma_req     = '0;
        idma_rdata  = 32'h0;
        ddma_rdata  = 32'h0;
        irq_src     = 1'b0;
        irq_ack     = 1'b0;
        br_req_in   = 1'b0;
        br_flit_in  = '0;
        mon_ack     = 1'b0;
        svc_ack     = 1'b0;
        ni_req      = 1'b0;
        ni_flit     = '0;
        br_ack_in   = 1'b0;
        wait (rst_n === 1'b1);
        test_memory_map();
        test_rtc_count();
        test_timer_irq();
        test_plic();
        test_br_split();
        test_br_stamp();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== sim.f ====
src/pe_pkg.sv
src/pe_bus_ctrl.sv
src/pe_rtc.sv
src/pe_plic.sv
src/br_local_port.sv
src/pe_periph_top.sv
verification/tb_clock.sv
verification/tb_pe_periph.sv
